/* rtl/scope_config.svh */
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

//////////////////////////////////////////////////
// raster geometry
//////////////////////////////////////////////////

// visible columns, also the number of stored trace columns
`define SCOPE_H_ACTIVE 800
`define SCOPE_V_ACTIVE 480
`define SCOPE_POS_WIDTH 10

//////////////////////////////////////////////////
// sample and trace widths
//////////////////////////////////////////////////

`define SCOPE_SAMPLE_WIDTH 12
// only the top bits of each sample end up on screen
`define SCOPE_TRACE_WIDTH 8

//////////////////////////////////////////////////
// scope window layout
//////////////////////////////////////////////////

`define SCOPE_WINDOW_TOP 224
`define SCOPE_CH0_BASE 224
`define SCOPE_CH1_BASE 256
`define SCOPE_CH2_BASE 288
`define SCOPE_CH3_BASE 320

// vertical line every 64 columns, horizontal line every 32 rows
`define SCOPE_GRID_COL_BITS 6
`define SCOPE_GRID_ROW_BITS 5

// address register plus memory read
`define SCOPE_BUFFER_LATENCY 2

`endif

/* rtl/scope_pkg.sv */
`include "scope_config.svh"

`default_nettype none

package scope_pkg;

	//////////////////////////////////////////////////
	// raster and sample types
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [`SCOPE_POS_WIDTH-1:0] x;
		logic [`SCOPE_POS_WIDTH-1:0] y;
	} pixel_pos_t;

	// ch[0] sits in the low bits
	typedef struct packed {
		logic [3:0][`SCOPE_SAMPLE_WIDTH-1:0] ch;
	} sample_set_t;

	//////////////////////////////////////////////////
	// trace column types
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [`SCOPE_TRACE_WIDTH-1:0] max;
		logic [`SCOPE_TRACE_WIDTH-1:0] min;
	} channel_range_t;

	// one buffer column, all four channels
	typedef struct packed {
		channel_range_t [3:0] ch;
	} trace_column_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t RGB_BLACK = 24'h000000;
	localparam rgb_t RGB_WHITE = 24'hffffff;
	localparam rgb_t RGB_RED = 24'hff0000;
	localparam rgb_t RGB_GREEN = 24'h00ff00;
	localparam rgb_t RGB_BLUE = 24'h0000ff;
	localparam rgb_t RGB_GREY = 24'h808080;

endpackage

`default_nettype wire

/* rtl/raster_tracker.sv */
`include "scope_config.svh"

`default_nettype none

module raster_tracker (
	input wire clk,
	input wire reset,
	input wire blank,
	input wire vsync,
	output scope_pkg::pixel_pos_t pos,
	output logic active,
	output logic frame_start,
	output logic frame_end
);

	logic blank_d;
	logic vsync_d;
	logic [`SCOPE_POS_WIDTH-1:0] x_cnt;
	logic [`SCOPE_POS_WIDTH-1:0] y_cnt;

	// x_cnt is the index of the pixel arriving in this cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d <= 1'b1;
			vsync_d <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			blank_d <= blank;
			vsync_d <= vsync;
			x_cnt <= blank ? '0 : x_cnt + 1'b1;
			// new line on each rising edge of blank
			if (vsync)
				y_cnt <= '0;
			else if (blank && !blank_d)
				y_cnt <= y_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
			active <= 1'b0;
			frame_start <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			pos.x <= x_cnt;
			pos.y <= y_cnt;
			active <= !blank && (y_cnt < `SCOPE_POS_WIDTH'(`SCOPE_V_ACTIVE));
			frame_start <= vsync && !vsync_d;
			frame_end <= !vsync && vsync_d;
		end
	end

endmodule

`default_nettype wire

/* rtl/range_tracker.sv */
`include "scope_config.svh"

`default_nettype none

module range_tracker (
	input wire clk,
	input wire reset,
	input wire sample_valid,
	input wire frame_start,
	input wire scope_pkg::sample_set_t samples,
	output scope_pkg::trace_column_t ranges
);

	localparam int SW = `SCOPE_SAMPLE_WIDTH;
	localparam int TW = `SCOPE_TRACE_WIDTH;

	logic [3:0][SW-1:0] run_min;
	logic [3:0][SW-1:0] run_max;
	// no sample seen since the last frame start
	logic empty;

	//////////////////////////////////////////////////
	// running min/max at full sample rate
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			for (int n = 0; n < 4; n++) begin
				if (empty || frame_start) begin
					run_min[n] <= samples.ch[n];
					run_max[n] <= samples.ch[n];
				end else begin
					if (samples.ch[n] < run_min[n])
						run_min[n] <= samples.ch[n];
					if (samples.ch[n] > run_max[n])
						run_max[n] <= samples.ch[n];
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// frame latch
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			empty <= 1'b1;
			ranges <= '0;
		end else if (frame_start) begin
			// an empty frame keeps the previous column
			if (!empty) begin
				for (int n = 0; n < 4; n++) begin
					ranges.ch[n].min <= run_min[n][SW-1 -: TW];
					ranges.ch[n].max <= run_max[n][SW-1 -: TW];
				end
			end
			empty <= !sample_valid;
		end else if (sample_valid) begin
			empty <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/trace_buffer.sv */
`include "scope_config.svh"

`default_nettype none

module trace_buffer (
	input wire clk,
	input wire reset,
	input wire frame_end,
	input wire scope_pkg::trace_column_t ranges,
	input wire scope_pkg::pixel_pos_t pos,
	output scope_pkg::trace_column_t column
);

	localparam int PW = `SCOPE_POS_WIDTH;
	localparam int DEPTH = `SCOPE_H_ACTIVE;

	scope_pkg::trace_column_t mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW:0] rd_sum;
	logic [PW-1:0] rd_addr;

	// wr_ptr points at the oldest column, so x = 0 is the left edge
	always_ff @(posedge clk) begin
		if (reset)
			wr_ptr <= '0;
		else if (frame_end)
			wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
	end

	always_comb begin
		rd_sum = {1'b0, wr_ptr} + {1'b0, pos.x};
		if (rd_sum >= (PW + 1)'(DEPTH))
			rd_sum = rd_sum - (PW + 1)'(DEPTH);
	end

	//////////////////////////////////////////////////
	// column memory, one write port and one read port
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		rd_addr <= rd_sum[PW-1:0];
	end

	always_ff @(posedge clk) begin
		if (frame_end)
			mem[wr_ptr] <= ranges;
		column <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* rtl/trace_renderer.sv */
`include "scope_config.svh"

`default_nettype none

module trace_renderer (
	input wire clk,
	input wire reset,
	input wire active,
	input wire scope_pkg::pixel_pos_t pos,
	input wire scope_pkg::trace_column_t column,
	output scope_pkg::rgb_t rgb
);

	localparam int PW = `SCOPE_POS_WIDTH;
	localparam int LAT = `SCOPE_BUFFER_LATENCY;
	localparam logic [3:0][PW-1:0] CH_BASE = {
		PW'(`SCOPE_CH3_BASE),
		PW'(`SCOPE_CH2_BASE),
		PW'(`SCOPE_CH1_BASE),
		PW'(`SCOPE_CH0_BASE)
	};

	scope_pkg::pixel_pos_t pos_pipe [LAT];
	logic [LAT-1:0] active_pipe;
	scope_pkg::pixel_pos_t pos_d;
	logic active_d;
	logic in_window;
	logic [3:0] band_lit;
	logic grid_lit;

	// true when y falls inside the channel band
	function automatic logic band_hit(
		input logic [PW-1:0] y,
		input logic [PW-1:0] base,
		input scope_pkg::channel_range_t r
	);
		logic [PW:0] offset;
		offset = {1'b0, y} - {1'b0, base};
		return !offset[PW] && (offset[PW-1:0] >= PW'(r.min))
			&& (offset[PW-1:0] <= PW'(r.max));
	endfunction

	//////////////////////////////////////////////////
	// align position with the buffer read
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		pos_pipe[0] <= pos;
		for (int i = 1; i < LAT; i++)
			pos_pipe[i] <= pos_pipe[i-1];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active_pipe <= '0;
		end else begin
			active_pipe[0] <= active;
			for (int i = 1; i < LAT; i++)
				active_pipe[i] <= active_pipe[i-1];
		end
	end

	assign pos_d = pos_pipe[LAT-1];
	assign active_d = active_pipe[LAT-1];
	assign in_window = active_d && (pos_d.y >= PW'(`SCOPE_WINDOW_TOP));

	//////////////////////////////////////////////////
	// pixel decisions
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			band_lit <= '0;
			grid_lit <= 1'b0;
		end else begin
			for (int n = 0; n < 4; n++)
				band_lit[n] <= in_window && band_hit(pos_d.y, CH_BASE[n], column.ch[n]);
			grid_lit <= in_window
				&& ((&pos_d.x[`SCOPE_GRID_COL_BITS-1:0])
				|| (pos_d.y[`SCOPE_GRID_ROW_BITS-1:0] == '0));
		end
	end

	// lower channel number wins, grid sits behind every band
	always_comb begin
		if (band_lit[0])
			rgb = scope_pkg::RGB_WHITE;
		else if (band_lit[1])
			rgb = scope_pkg::RGB_RED;
		else if (band_lit[2])
			rgb = scope_pkg::RGB_GREEN;
		else if (band_lit[3])
			rgb = scope_pkg::RGB_BLUE;
		else if (grid_lit)
			rgb = scope_pkg::RGB_GREY;
		else
			rgb = scope_pkg::RGB_BLACK;
	end

endmodule

`default_nettype wire

/* rtl/vga_scope_top.sv */
`default_nettype none

module vga_scope_top (
	input wire clk,
	input wire reset,
	input wire blank,
	input wire vsync,
	input wire sample_valid,
	input wire scope_pkg::sample_set_t samples,
	output scope_pkg::rgb_t rgb
);

	scope_pkg::pixel_pos_t pos;
	logic active;
	logic frame_start;
	logic frame_end;
	scope_pkg::trace_column_t ranges;
	scope_pkg::trace_column_t column;

	raster_tracker u_raster (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.pos(pos),
		.active(active),
		.frame_start(frame_start),
		.frame_end(frame_end)
	);

	// min/max latched on vsync rise
	range_tracker u_range (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.frame_start(frame_start),
		.samples(samples),
		.ranges(ranges)
	);

	// column written on vsync fall
	trace_buffer u_buffer (
		.clk(clk),
		.reset(reset),
		.frame_end(frame_end),
		.ranges(ranges),
		.pos(pos),
		.column(column)
	);

	trace_renderer u_render (
		.clk(clk),
		.reset(reset),
		.active(active),
		.pos(pos),
		.column(column),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

/* verification/scope_tb.sv */
`include "scope_config.svh"

`default_nettype none

module scope_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACTIVE = `SCOPE_H_ACTIVE;
	localparam int V_ACTIVE = `SCOPE_V_ACTIVE;
	localparam int BLANK_GAP = 8;
	localparam int VSYNC_LEN = 8;
	localparam int SAMPLE_X = 100;
	localparam int PIPE_DEPTH = 4;
	localparam int DRAIN_TIMEOUT = 100;
	localparam int N_ROWS = 6;
	localparam int BAND_BASE [4] = '{`SCOPE_CH0_BASE, `SCOPE_CH1_BASE,
		`SCOPE_CH2_BASE, `SCOPE_CH3_BASE};
	// white, red, green, blue
	localparam logic [23:0] BAND_RGB [4] = '{24'hffffff, 24'hff0000, 24'h00ff00, 24'h0000ff};

	typedef struct packed {
		logic active;
		logic [`SCOPE_POS_WIDTH-1:0] x;
		logic [`SCOPE_POS_WIDTH-1:0] y;
	} pixel_info_t;

	typedef struct packed {
		logic [3:0][`SCOPE_SAMPLE_WIDTH-1:0] lo;
		logic [3:0][`SCOPE_SAMPLE_WIDTH-1:0] hi;
		logic [8:0] count;
	} frame_row_t;

	// one row per frame, channels given ch3 first, count 0 means no samples
	localparam frame_row_t FRAME_TABLE [N_ROWS] = '{
		{{12'h000, 12'h200, 12'h050, 12'h100}, {12'h0ff, 12'h3f0, 12'h0a0, 12'h1ff}, 9'd40},
		{{12'h800, 12'h000, 12'h300, 12'h400}, {12'hc00, 12'hfff, 12'h9ff, 12'h7ff}, 9'd480},
		{{12'hfff, 12'h00f, 12'habc, 12'h123}, {12'hfff, 12'h011, 12'habc, 12'h12f}, 9'd12},
		{{12'h000, 12'h000, 12'h000, 12'h000}, {12'h000, 12'h000, 12'h000, 12'h000}, 9'd0},
		{{12'h100, 12'h180, 12'h000, 12'h0f0}, {12'h6ff, 12'h5ff, 12'h2ff, 12'h4ff}, 9'd200},
		{{12'h400, 12'h700, 12'h100, 12'h000}, {12'h4ff, 12'h7ff, 12'h1ff, 12'h0ff}, 9'd3}
	};

	logic clk = 1'b0;
	logic reset;
	logic blank;
	logic vsync;
	logic sample_valid;
	scope_pkg::sample_set_t samples;
	scope_pkg::rgb_t rgb;

	logic [31:0] lfsr_state = 32'hc074f64d;
	pixel_info_t pix_now = '0;
	pixel_info_t pix_pipe [PIPE_DEPTH] = '{default: '0};
	// written columns, newest at the back
	scope_pkg::trace_column_t col_hist [$];
	string test_name = "reset";
	int pixels_driven = 0;
	int pixels_checked = 0;

	vga_scope_top dut (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.sample_valid(sample_valid),
		.samples(samples),
		.rgb(rgb)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// random numbers and stimulus values
	//////////////////////////////////////////////////

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	// start mid range so the next two samples widen the max and then the min
	function automatic scope_pkg::sample_set_t sample_for(input frame_row_t row, input int k);
		scope_pkg::sample_set_t s;
		int lo;
		int span;
		int v;
		for (int n = 0; n < 4; n++) begin
			lo = int'(row.lo[n]);
			span = int'(row.hi[n]) - lo;
			if (k == 0)
				v = lo + span / 2;
			else if (k == 1)
				v = lo + span;
			else if (k == 2)
				v = lo;
			else if (k % 2 == 0)
				v = lo + span * k / (int'(row.count) - 1);
			else
				v = lo + random_bits(12) % (span + 1);
			s.ch[n] = `SCOPE_SAMPLE_WIDTH'(v);
		end
		return s;
	endfunction

	//////////////////////////////////////////////////
	// reference model and checks
	//////////////////////////////////////////////////

	function automatic logic [23:0] expected_rgb(input pixel_info_t p,
			input scope_pkg::trace_column_t c);
		int off;
		for (int n = 0; n < 4; n++) begin
			off = int'(p.y) - BAND_BASE[n];
			if (off >= int'(c.ch[n].min) && off <= int'(c.ch[n].max))
				return BAND_RGB[n];
		end
		if (int'(p.x) % 64 == 63 || int'(p.y) % 32 == 0)
			return 24'h808080;
		return 24'h000000;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input int x, input int y,
			input logic [23:0] expected, input logic [23:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("MISMATCH %s x=%0d y=%0d expected %h actual %h",
				name, x, y, expected, actual));
	endtask

	// mirrors the four cycle latency from input pixel to rgb
	always @(posedge clk) begin
		pix_pipe[0] <= pix_now;
		for (int i = 1; i < PIPE_DEPTH; i++)
			pix_pipe[i] <= pix_pipe[i-1];
	end

	always @(negedge clk) begin : compare_output
		pixel_info_t p;
		int age;
		p = pix_pipe[PIPE_DEPTH-1];
		age = H_ACTIVE - 1 - int'(p.x);
		if (p.active)
			pixels_checked++;
		if (!p.active || int'(p.y) < `SCOPE_WINDOW_TOP)
			check_equal(test_name, int'(p.x), int'(p.y), 24'h000000, rgb);
		else if (age < col_hist.size())
			check_equal(test_name, int'(p.x), int'(p.y),
				expected_rgb(p, col_hist[col_hist.size() - 1 - age]), rgb);
	end

	//////////////////////////////////////////////////
	// raster driver
	//////////////////////////////////////////////////

	task automatic drive_line(input int y, input frame_row_t row);
		for (int x = 0; x < H_ACTIVE; x++) begin
			@(posedge clk);
			blank <= 1'b0;
			pix_now <= '{active: 1'b1, x: `SCOPE_POS_WIDTH'(x), y: `SCOPE_POS_WIDTH'(y)};
			if (x == SAMPLE_X && y < int'(row.count)) begin
				sample_valid <= 1'b1;
				samples <= sample_for(row, y);
			end else begin
				sample_valid <= 1'b0;
			end
			pixels_driven++;
		end
		repeat (BLANK_GAP) begin
			@(posedge clk);
			blank <= 1'b1;
			sample_valid <= 1'b0;
			pix_now <= '0;
		end
	endtask

	task automatic drive_frame(input string name, input frame_row_t row);
		test_name = name;
		for (int y = 0; y < V_ACTIVE; y++)
			drive_line(y, row);
	endtask

	// the new column is written just after vsync falls
	task automatic drive_vsync(input frame_row_t row);
		scope_pkg::trace_column_t c;
		repeat (VSYNC_LEN) begin
			@(posedge clk);
			vsync <= 1'b1;
		end
		@(posedge clk);
		vsync <= 1'b0;
		if (row.count != 0) begin
			for (int n = 0; n < 4; n++) begin
				c.ch[n].min = row.lo[n][`SCOPE_SAMPLE_WIDTH-1 -: `SCOPE_TRACE_WIDTH];
				c.ch[n].max = row.hi[n][`SCOPE_SAMPLE_WIDTH-1 -: `SCOPE_TRACE_WIDTH];
			end
			col_hist.push_back(c);
		end else begin
			col_hist.push_back(col_hist[$]);
		end
		repeat (BLANK_GAP) @(posedge clk);
	endtask

	initial begin : stimulus
		int waited;
		reset = 1'b1;
		blank = 1'b1;
		vsync = 1'b0;
		sample_valid = 1'b0;
		samples = '0;
		waited = 0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (BLANK_GAP) @(posedge clk);
		for (int f = 0; f < N_ROWS; f++) begin
			drive_frame($sformatf("frame %0d", f), FRAME_TABLE[f]);
			drive_vsync(FRAME_TABLE[f]);
		end
		// one more frame so the last column is shown at x = 799
		drive_frame("display", '0);
		while (pixels_checked != pixels_driven && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (pixels_checked != pixels_driven) begin
			stop_with_failure("timeout: not every driven pixel reached the output check");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/scope_pkg.sv
rtl/raster_tracker.sv
rtl/range_tracker.sv
rtl/trace_buffer.sv
rtl/trace_renderer.sv
rtl/vga_scope_top.sv
verification/scope_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = scope_tb
FILELIST = src.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out=$$(./$(BUILD)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD)
